// File: verilog.f
vrc_pkg.sv
vrc_reg_decode.sv
vrc_bank_regs.sv
vrc_irq.sv
vrc_addr_map.sv
vrc_mapper.sv
tb_vrc_mapper.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_vrc_mapper \
	-f verilog.f -o sim_vrc

./obj_dir/sim_vrc > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Everything OK" sim.log; then
	echo "simulation ended without finishing the tests"
	exit 1
fi

// File: tb_vrc_mapper.sv
`timescale 1ns/10ps

module tb_vrc_mapper;

	// All tests together take a little under 1000 cycles.
	localparam int CYCLE_LIMIT = 3000;

	logic               m2 = 1'b0;
	logic               rst;
	vrc_pkg::cpu_bus_t  cpu;
	vrc_pkg::ppu_bus_t  ppu;
	vrc_pkg::map_cfg_t  cfg;
	vrc_pkg::sst_bus_t  sst;
	logic [7:0]         prg_do;
	logic [7:0]         chr_do;
	logic [7:0]         srm_do;
	vrc_pkg::mem_ctrl_t prg;
	vrc_pkg::mem_ctrl_t chr;
	vrc_pkg::mem_ctrl_t srm;
	logic               cpu_oe;
	logic [7:0]         cpu_do;
	logic               ppu_oe;
	logic [7:0]         ppu_do;
	logic               ciram_a10;
	logic               ciram_ce;
	logic               irq;
	logic [7:0]         sst_di;
	logic [31:0]        lfsr = 32'hf8d9;
	logic [8:0]         chr_val [8];
	int                 cycles = 0;

	vrc_mapper dut (.*);

	always #50 m2 = ~m2;

	// Memory contents fold every address bit into the byte.
	function automatic logic [7:0] mem_byte(input logic [20:0] addr, input logic [7:0] salt);
		return addr[7:0] ^ addr[15:8] ^ {3'd0, addr[20:16]} ^ salt;
	endfunction

	assign prg_do = mem_byte(prg.addr, 8'h00);
	assign chr_do = mem_byte(chr.addr, 8'h5A);
	assign srm_do = mem_byte(srm.addr, 8'hC3);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "Run stopped at the first error.");
	endtask

	always @(posedge m2)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			report_failure("Timeout: the tests did not finish within the cycle limit.");
	end

	// Galois LFSR, one step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	task automatic check_mem(input vrc_pkg::mem_ctrl_t got, input vrc_pkg::mem_ctrl_t exp,
		input string what);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// CPU address that reaches register s of a page on the given board.
	function automatic logic [15:0] board_addr(input logic [3:0] page, input logic [1:0] s,
		input vrc_pkg::map_cfg_t c);
		logic [15:0] addr;
		logic [1:0]  lines;
		addr = {page, 12'h000};
		lines = (c.map_idx == 8'd25) ? {s[0], s[1]} : s; // 25 swaps the pair.
		if (c.map_idx == 8'd21)
		begin
			if (c.map_sub == 2'd1)
				addr[2:1] = s;
			else
				addr[7:6] = s;
		end
		else if (c.map_idx == 8'd22)
			addr[1:0] = {s[0], s[1]};
		else if (c.map_sub == 2'd1 || c.map_sub == 2'd3)
			addr[1:0] = lines;
		else
			addr[3:2] = lines;
		return addr;
	endfunction

	function automatic logic [7:0] expected_prg_bank(input int w, input logic [7:0] p0,
		input logic [7:0] p1, input logic swp);
		case (w)
			0: return swp ? 8'hFE : p0;
			1: return p1;
			2: return swp ? p0 : 8'hFE;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic set_cfg(input vrc_pkg::map_cfg_t c);
		@(posedge m2);
		cfg <= c;
	endtask

	// The DUT takes the write on the falling edge in between.
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge m2);
		cpu <= '{addr: addr, data: data, rw: 1'b0};
		@(posedge m2);
		cpu <= '{addr: 16'h0000, data: 8'h00, rw: 1'b1};
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		@(posedge m2);
		cpu <= '{addr: addr, data: 8'h00, rw: 1'b1};
		@(posedge m2);
	endtask

	task automatic ppu_read(input logic [13:0] addr);
		@(posedge m2);
		ppu <= '{addr: addr, oe: 1'b0, we: 1'b1};
		@(posedge m2);
	endtask

	task automatic sst_write(input logic [7:0] slot, input logic [7:0] data);
		vrc_pkg::sst_bus_t s;
		s.act = 1'b1;
		s.we_reg = 1'b1;
		s.addr.raw = slot;
		s.dato = data;
		@(posedge m2);
		sst <= s;
		@(posedge m2);
		sst <= '0;
	endtask

	task automatic sst_read(input logic [7:0] slot, input logic [7:0] exp, input string what);
		vrc_pkg::sst_bus_t s;
		s = '0;
		s.act = 1'b1;
		s.addr.raw = slot;
		@(posedge m2);
		sst <= s;
		@(posedge m2);
		check_byte(sst_di, exp, what);
	endtask

	task automatic check_prg_windows(input logic [7:0] p0, input logic [7:0] p1,
		input logic swp);
		logic [15:0]        addr;
		vrc_pkg::mem_ctrl_t exp;
		for (int w = 0; w < 4; w++)
		begin
			addr = {1'b1, 2'(w), 13'(rand_bits(13))};
			cpu_read(addr);
			exp.addr = {expected_prg_bank(w, p0, p1, swp), addr[12:0]};
			exp.ce = 1'b1;
			exp.oe = 1'b1;
			exp.we = 1'b0;
			check_mem(prg, exp, "prg window");
			check_bit(cpu_oe, 1'b1, "cpu_oe on ROM read");
			check_byte(cpu_do, mem_byte(exp.addr, 8'h00), "cpu_do from PRG ROM");
		end
	endtask

	// One CPU access to the 6000-7FFF save RAM.
	task automatic check_sram_window(input logic rd);
		logic [15:0]        addr;
		vrc_pkg::mem_ctrl_t exp;
		addr = {3'b011, 13'(rand_bits(13))};
		@(posedge m2);
		cpu <= '{addr: addr, data: 8'(rand_bits(8)), rw: rd};
		@(posedge m2);
		exp.addr = {8'd0, addr[12:0]};
		exp.ce = 1'b1;
		exp.oe = rd;
		exp.we = !rd;
		check_mem(srm, exp, "srm window");
		if (rd)
		begin
			check_bit(cpu_oe, 1'b1, "cpu_oe on save RAM read");
			check_byte(cpu_do, mem_byte(exp.addr, 8'hC3), "cpu_do from save RAM");
		end
		cpu <= '{addr: 16'h0000, data: 8'h00, rw: 1'b1};
	endtask

	task automatic check_chr_windows(input logic halve);
		logic [13:0]        paddr;
		logic [8:0]         bank;
		vrc_pkg::mem_ctrl_t exp;
		for (int w = 0; w < 8; w++)
		begin
			paddr = {1'b0, 3'(w), 10'(rand_bits(10))};
			ppu_read(paddr);
			bank = halve ? {1'b0, chr_val[w][8:1]} : chr_val[w];
			exp.addr = {2'b00, bank, paddr[9:0]};
			exp.ce = 1'b1;
			exp.oe = 1'b1;
			exp.we = 1'b0;
			check_mem(chr, exp, "chr window");
			check_bit(ppu_oe, 1'b1, "ppu_oe on CHR read");
			check_byte(ppu_do, mem_byte(exp.addr, 8'h5A), "ppu_do from CHR ROM");
		end
	endtask

	task automatic reset_defaults();
		check_prg_windows(8'h00, 8'h01, 1'b0);
		ppu_read(14'(rand_bits(13)));
		check_bit(ciram_a10, 1'b1, "one-screen ciram_a10 after reset");
		check_bit(irq, 1'b0, "irq after reset");
	endtask

	task automatic prg_banking();
		vrc_pkg::map_cfg_t c;
		logic [7:0]        p0;
		logic [7:0]        p1;
		for (int m = 0; m < 3; m++)
		begin
			for (int sub = 0; sub < 3; sub++)
			begin
				c = '{map_idx: (m == 0) ? 8'd21 : (m == 1) ? 8'd23 : 8'd25,
					map_sub: 2'(sub), chr_ram: 1'b0, prg_ram_off: 1'b0};
				set_cfg(c);
				p0 = 8'(rand_bits(8));
				p1 = 8'(rand_bits(8));
				cpu_write(board_addr(4'h8, 2'(rand_bits(2)), c), p0);
				cpu_write(board_addr(4'hA, 2'(rand_bits(2)), c), p1);
				for (int swp = 0; swp < 2; swp++)
				begin
					cpu_write(board_addr(4'h9, 2'd2, c),
						{6'(rand_bits(6)), 1'(swp), 1'(rand_bits(1))});
					check_prg_windows(p0, p1, 1'(swp));
				end
			end
		end
	endtask

	task automatic chr_banking();
		vrc_pkg::map_cfg_t c;
		c = '{map_idx: 8'd23, map_sub: 2'd1, chr_ram: 1'b0, prg_ram_off: 1'b0};
		set_cfg(c);
		for (int k = 0; k < 8; k++)
		begin
			chr_val[k] = 9'(rand_bits(9));
			cpu_write(board_addr(4'(11 + k / 2), {1'(k % 2), 1'b0}, c),
				{4'(rand_bits(4)), chr_val[k][3:0]});
			cpu_write(board_addr(4'(11 + k / 2), {1'(k % 2), 1'b1}, c),
				{3'(rand_bits(3)), chr_val[k][8:4]});
		end
		check_chr_windows(1'b0);
		c.map_idx = 8'd22; // Same registers, board drops bit 0.
		set_cfg(c);
		check_chr_windows(1'b1);
	endtask

	task automatic mirroring();
		vrc_pkg::map_cfg_t c;
		logic [13:0]       paddr;
		logic [1:0]        mir;
		logic              exp_a10;
		c = '{map_idx: 8'd23, map_sub: 2'd1, chr_ram: 1'b0, prg_ram_off: 1'b0};
		for (int v = 0; v < 6; v++)
		begin
			c.map_sub = (v < 4) ? 2'd1 : 2'd3; // Last two runs on VRC2.
			mir = 2'(v);
			set_cfg(c);
			cpu_write(board_addr(4'h9, 2'd0, c), {6'(rand_bits(6)), mir});
			for (int p = 0; p < 8; p++)
			begin
				paddr = 14'(rand_bits(14));
				paddr[13] = 1'(p >> 2);
				paddr[11:10] = 2'(p);
				ppu_read(paddr);
				if (mir[1])
					exp_a10 = mir[0];
				else if (mir[0])
					exp_a10 = paddr[11];
				else
					exp_a10 = paddr[10];
				check_bit(ciram_a10, exp_a10, "ciram_a10");
				check_bit(ciram_ce, !paddr[13], "ciram_ce");
			end
		end
	endtask

	task automatic irq_cycle_mode();
		vrc_pkg::map_cfg_t c;
		logic [7:0]        latch;
		c = '{map_idx: 8'd23, map_sub: 2'd1, chr_ram: 1'b0, prg_ram_off: 1'b0};
		set_cfg(c);
		latch = 8'(rand_bits(8));
		cpu_write(board_addr(4'hF, 2'd0, c), {4'h0, latch[3:0]});
		cpu_write(board_addr(4'hF, 2'd1, c), {4'h0, latch[7:4]});
		cpu_write(board_addr(4'hF, 2'd2, c), 8'h06); // Cycle mode, enabled.
		for (int n = 0; n < 255 - int'(latch); n++)
		begin
			@(posedge m2);
			check_bit(irq, 1'b0, "irq before the counter wraps");
		end
		@(posedge m2);
		check_bit(irq, 1'b1, "irq when the counter wraps");
		cpu_write(board_addr(4'hF, 2'd3, c), 8'h00);
		@(posedge m2);
		check_bit(irq, 1'b0, "irq after acknowledge");
		c.map_sub = 2'd3;
		set_cfg(c);
		cpu_write(board_addr(4'hF, 2'd0, c), 8'h08);
		cpu_write(board_addr(4'hF, 2'd1, c), 8'h0F);
		cpu_write(board_addr(4'hF, 2'd2, c), 8'h06);
		repeat (24)
		begin
			@(posedge m2);
			check_bit(irq, 1'b0, "irq on a VRC2 board");
		end
		cpu_write(board_addr(4'hF, 2'd2, c), 8'h00);
	endtask

	task automatic save_state();
		vrc_pkg::map_cfg_t c;
		logic [7:0]        p0;
		logic [7:0]        p1;
		logic [7:0]        b;
		logic [2:0]        mode;
		logic [15:0]       addr;
		c = '{map_idx: 8'd23, map_sub: 2'd1, chr_ram: 1'b0, prg_ram_off: 1'b0};
		set_cfg(c);
		p0 = 8'(rand_bits(8));
		p1 = 8'(rand_bits(8));
		mode = {1'b1, 2'(rand_bits(2))};
		sst_write(vrc_pkg::SST_PRG0, p0);
		sst_write(vrc_pkg::SST_PRG1, p1);
		sst_write(vrc_pkg::SST_MODE, {5'(rand_bits(5)), mode});
		for (int k = 0; k < 8; k++)
		begin
			chr_val[k] = 9'(rand_bits(9));
			sst_write(vrc_pkg::SST_CHR_LO + 8'(k), chr_val[k][7:0]);
			sst_write(vrc_pkg::SST_CHR_HI + 8'(k), {7'(rand_bits(7)), chr_val[k][8]});
		end
		sst_read(vrc_pkg::SST_PRG0, p0, "prg0 slot");
		sst_read(vrc_pkg::SST_PRG1, p1, "prg1 slot");
		sst_read(vrc_pkg::SST_MODE, {5'd0, mode}, "mode slot");
		for (int k = 0; k < 8; k++)
		begin
			sst_read(vrc_pkg::SST_CHR_LO + 8'(k), chr_val[k][7:0], "chr low slot");
			sst_read(vrc_pkg::SST_CHR_HI + 8'(k), {7'd0, chr_val[k][8]}, "chr high slot");
		end
		sst_write(vrc_pkg::SST_IRQ_CTRL, 8'h04); // Cycle mode, counter stopped.
		sst_read(vrc_pkg::SST_IRQ_CTRL, 8'h04, "irq control slot");
		b = 8'(rand_bits(8));
		sst_write(vrc_pkg::SST_IRQ_LATCH, b);
		sst_read(vrc_pkg::SST_IRQ_LATCH, b, "irq latch slot");
		b = 8'(rand_bits(8));
		sst_write(vrc_pkg::SST_IRQ_CNT, b);
		sst_read(vrc_pkg::SST_IRQ_CNT, b, "irq counter slot");
		b = 8'(rand_bits(8));
		sst_write(vrc_pkg::SST_IRQ_PRE_LO, b);
		sst_write(vrc_pkg::SST_IRQ_PRE_HI, 8'hFF);
		sst_read(vrc_pkg::SST_IRQ_PRE_LO, b, "prescaler low slot");
		sst_read(vrc_pkg::SST_IRQ_PRE_HI, 8'h01, "prescaler high slot");
		sst_read(vrc_pkg::SST_MAP_IDX, 8'd23, "mapper number slot");
		sst_read(8'd19, 8'hFF, "unused slot 19");
		sst_read(8'd31, 8'hFF, "unused slot 31");
		sst_read(8'd37, 8'hFF, "unused slot 37");
		sst_read(8'd100, 8'hFF, "unused slot 100");
		check_prg_windows(p0, p1, mode[2]);
		check_chr_windows(1'b0);
		c = '{map_idx: 8'd22, map_sub: 2'd0, chr_ram: 1'b0, prg_ram_off: 1'b1};
		set_cfg(c);
		repeat (4)
		begin
			b = 8'(rand_bits(8));
			cpu_write(16'h6000 + 16'(rand_bits(12)), b);
			addr = 16'h6000 + 16'(rand_bits(12));
			cpu_read(addr);
			check_bit(cpu_oe, 1'b1, "cpu_oe on latch read");
			check_byte(cpu_do, {addr[15:9], b[0]}, "VRC2 latch read");
		end
		c.prg_ram_off = 1'b0; // Save RAM answers where the latch was.
		set_cfg(c);
		check_sram_window(1'b1);
		check_sram_window(1'b0);
	endtask

	initial
	begin
		rst = 1'b1;
		cpu = '{addr: 16'h0000, data: 8'h00, rw: 1'b1};
		ppu = '{addr: 14'h0000, oe: 1'b1, we: 1'b1};
		cfg = '{map_idx: 8'd23, map_sub: 2'd0, chr_ram: 1'b0, prg_ram_off: 1'b0};
		sst = '0;
		repeat (8) @(posedge m2);
		rst <= 1'b0;
		reset_defaults();
		prg_banking();
		chr_banking();
		mirroring();
		irq_cycle_mode();
		save_state();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: vrc_mapper.sv
`timescale 1ns/10ps

module vrc_mapper (
	input  logic               m2,
	input  logic               rst,
	input  vrc_pkg::cpu_bus_t  cpu,
	input  vrc_pkg::ppu_bus_t  ppu,
	input  vrc_pkg::map_cfg_t  cfg,
	input  vrc_pkg::sst_bus_t  sst,
	input  logic [7:0]         prg_do,
	input  logic [7:0]         chr_do,
	input  logic [7:0]         srm_do,
	output vrc_pkg::mem_ctrl_t prg,
	output vrc_pkg::mem_ctrl_t chr,
	output vrc_pkg::mem_ctrl_t srm,
	output logic               cpu_oe,
	output logic [7:0]         cpu_do,
	output logic               ppu_oe,
	output logic [7:0]         ppu_do,
	output logic               ciram_a10,
	output logic               ciram_ce,
	output logic               irq,
	output logic [7:0]         sst_di
);
	vrc_pkg::reg_sel_t    sel;
	vrc_pkg::bank_state_t banks;
	logic [7:0]           bank_sst_di;
	logic [7:0]           irq_sst_di;
	logic                 latch_ce;
	logic                 irq_pend;

	vrc_reg_decode u_decode (
		.cpu (cpu),
		.cfg (cfg),
		.sel (sel)
	);

	vrc_bank_regs u_banks (
		.m2       (m2),
		.rst      (rst),
		.cpu      (cpu),
		.cfg      (cfg),
		.sel      (sel),
		.sst      (sst),
		.banks    (banks),
		.sst_di   (bank_sst_di),
		.latch_ce (latch_ce)
	);

	vrc_irq u_irq (
		.m2       (m2),
		.rst      (rst),
		.cpu      (cpu),
		.sel      (sel),
		.sst      (sst),
		.irq_pend (irq_pend),
		.sst_di   (irq_sst_di)
	);

	vrc_addr_map u_map (
		.cpu       (cpu),
		.ppu       (ppu),
		.cfg       (cfg),
		.banks     (banks),
		.latch_ce  (latch_ce),
		.prg_do    (prg_do),
		.chr_do    (chr_do),
		.srm_do    (srm_do),
		.prg       (prg),
		.chr       (chr),
		.srm       (srm),
		.cpu_oe    (cpu_oe),
		.cpu_do    (cpu_do),
		.ppu_oe    (ppu_oe),
		.ppu_do    (ppu_do),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

	// Bank block already answers FF for slots nobody owns.
	always_comb
	begin
		if (sst.addr.raw >= vrc_pkg::SST_IRQ_LATCH && sst.addr.raw <= vrc_pkg::SST_IRQ_PRE_HI)
			sst_di = irq_sst_di;
		else if (sst.addr.raw == vrc_pkg::SST_MAP_IDX)
			sst_di = cfg.map_idx;
		else
			sst_di = bank_sst_di;
	end

	assign irq = irq_pend && sel.is_vrc4; // VRC2 has no IRQ pin.

endmodule

// File: vrc_addr_map.sv
`timescale 1ns/10ps

module vrc_addr_map (
	input  vrc_pkg::cpu_bus_t    cpu,
	input  vrc_pkg::ppu_bus_t    ppu,
	input  vrc_pkg::map_cfg_t    cfg,
	input  vrc_pkg::bank_state_t banks,
	input  logic                 latch_ce,
	input  logic [7:0]           prg_do,
	input  logic [7:0]           chr_do,
	input  logic [7:0]           srm_do,
	output vrc_pkg::mem_ctrl_t   prg,
	output vrc_pkg::mem_ctrl_t   chr,
	output vrc_pkg::mem_ctrl_t   srm,
	output logic                 cpu_oe,
	output logic [7:0]           cpu_do,
	output logic                 ppu_oe,
	output logic [7:0]           ppu_do,
	output logic                 ciram_a10,
	output logic                 ciram_ce
);
	logic [7:0] prg_bank;
	logic [8:0] chr_reg;
	logic [8:0] chr_bank;
	logic       latch_rd;

	// 8 KB windows at 8000, A000, C000, E000.
	always_comb
	begin
		case (cpu.addr[14:13])
			2'd0: prg_bank = banks.swp_mode ? vrc_pkg::PRG_BANK_FE : banks.prg0;
			2'd1: prg_bank = banks.prg1;
			2'd2: prg_bank = banks.swp_mode ? banks.prg0 : vrc_pkg::PRG_BANK_FE;
			default: prg_bank = vrc_pkg::PRG_BANK_FF;
		endcase
	end

	assign prg.ce   = cpu.addr[15];
	assign prg.oe   = cpu.rw;
	assign prg.we   = 1'b0;
	assign prg.addr = {prg_bank, cpu.addr[12:0]};

	assign srm.ce   = cpu.addr[15:13] == vrc_pkg::SRM_BASE[15:13];
	assign srm.oe   = cpu.rw;
	assign srm.we   = !cpu.rw;
	assign srm.addr = {8'd0, cpu.addr[12:0]};

	// Mapper 22 boards drop the low CHR bank bit.
	assign chr_reg  = banks.chr[ppu.addr[12:10]];
	assign chr_bank = (cfg.map_idx == vrc_pkg::MAP_22) ? {1'b0, chr_reg[8:1]} : chr_reg;

	assign chr.ce   = !ppu.addr[13];
	assign chr.oe   = !ppu.oe;
	assign chr.we   = cfg.chr_ram && !ppu.we && !ppu.addr[13];
	assign chr.addr = {2'b00, chr_bank, ppu.addr[9:0]};

	assign ciram_a10 = banks.mir_mode[1] ? banks.mir_mode[0] :
		banks.mir_mode[0] ? ppu.addr[11] : ppu.addr[10]; // A10 vertical, A11 horizontal.
	assign ciram_ce  = !ppu.addr[13];

	assign latch_rd = cpu.rw && latch_ce;
	assign cpu_oe   = latch_rd || (srm.ce && srm.oe) || (prg.ce && prg.oe);
	assign cpu_do   = latch_rd ? {cpu.addr[15:9], banks.vrc2_latch} :
		srm.ce ? srm_do : prg_do; // Open bus bits around the latch.

	assign ppu_oe = chr.ce && chr.oe;
	assign ppu_do = chr_do;

endmodule

// File: vrc_irq.sv
`timescale 1ns/10ps

module vrc_irq (
	input  logic              m2,
	input  logic              rst,
	input  vrc_pkg::cpu_bus_t cpu,
	input  vrc_pkg::reg_sel_t sel,
	input  vrc_pkg::sst_bus_t sst,
	output logic              irq_pend,
	output logic [7:0]        sst_di
);
	logic [7:0] irq_latch;
	logic [7:0] irq_cnt;
	logic [8:0] prescale;
	logic [8:0] prescale_next;
	logic       pre_wrap;
	logic       tick;
	logic       irq_en;
	logic       irq_en_ack;
	logic       irq_mode; // Set for cycle mode.
	logic       sst_wr;
	logic       cpu_wr;

	assign sst_wr = sst.act && sst.we_reg;
	assign cpu_wr = !cpu.rw;

	// Three steps per CPU cycle, one scanline every 341 PPU dots.
	assign prescale_next = prescale + vrc_pkg::PRESCALE_STEP;
	assign pre_wrap      = prescale_next >= vrc_pkg::PRESCALE_LIMIT;
	assign tick          = irq_mode || pre_wrap;

	always_ff @(negedge m2)
	begin
		if (sst_wr)
		begin
			case (sst.addr.raw)
				vrc_pkg::SST_IRQ_LATCH: irq_latch <= sst.dato;
				vrc_pkg::SST_IRQ_CTRL: {irq_pend, irq_mode, irq_en, irq_en_ack} <= sst.dato[3:0];
				vrc_pkg::SST_IRQ_CNT: irq_cnt <= sst.dato;
				vrc_pkg::SST_IRQ_PRE_LO: prescale[7:0] <= sst.dato;
				vrc_pkg::SST_IRQ_PRE_HI: prescale[8] <= sst.dato[0];
				default: ;
			endcase
		end
		else if (rst)
		begin
			irq_en     <= 1'b0;
			irq_en_ack <= 1'b0;
			irq_mode   <= 1'b0;
			irq_pend   <= 1'b0;
			prescale   <= 9'd0;
		end
		else
		begin
			if (irq_en)
			begin
				prescale <= pre_wrap ? prescale_next - vrc_pkg::PRESCALE_LIMIT : prescale_next;
				if (tick)
				begin
					if (irq_cnt == 8'hFF)
					begin
						irq_cnt  <= irq_latch;
						irq_pend <= 1'b1;
					end
					else
						irq_cnt <= irq_cnt + 8'd1;
				end
			end
			// Register writes override the count on the same edge.
			if (cpu_wr)
			begin
				case (sel.reg_addr)
					vrc_pkg::REG_IRQ_LATCH_LO: irq_latch[3:0] <= cpu.data[3:0];
					vrc_pkg::REG_IRQ_LATCH_HI: irq_latch[7:4] <= cpu.data[3:0];
					vrc_pkg::REG_IRQ_CTRL:
					begin
						irq_en_ack <= cpu.data[0];
						irq_en     <= cpu.data[1];
						irq_mode   <= cpu.data[2];
						irq_pend   <= 1'b0;
						irq_cnt    <= irq_latch;
						prescale   <= 9'd0;
					end
					vrc_pkg::REG_IRQ_ACK:
					begin
						irq_pend <= 1'b0;
						irq_en   <= irq_en_ack;
					end
					default: ;
				endcase
			end
		end
	end

	always_comb
	begin
		case (sst.addr.raw)
			vrc_pkg::SST_IRQ_LATCH: sst_di = irq_latch;
			vrc_pkg::SST_IRQ_CTRL: sst_di = {4'd0, irq_pend, irq_mode, irq_en, irq_en_ack};
			vrc_pkg::SST_IRQ_CNT: sst_di = irq_cnt;
			vrc_pkg::SST_IRQ_PRE_LO: sst_di = prescale[7:0];
			vrc_pkg::SST_IRQ_PRE_HI: sst_di = {7'd0, prescale[8]};
			default: sst_di = 8'hFF;
		endcase
	end

	// Pending comes from an overflow while enabled, or from a restore.
	assert property (@(negedge m2) disable iff (rst)
		$rose(irq_pend) |-> $past(irq_en || sst_wr))
		else $error("irq pending rose with the counter disabled");

endmodule

// File: vrc_bank_regs.sv
`timescale 1ns/10ps

module vrc_bank_regs (
	input  logic                 m2,
	input  logic                 rst,
	input  vrc_pkg::cpu_bus_t    cpu,
	input  vrc_pkg::map_cfg_t    cfg,
	input  vrc_pkg::reg_sel_t    sel,
	input  vrc_pkg::sst_bus_t    sst,
	output vrc_pkg::bank_state_t banks,
	output logic [7:0]           sst_di,
	output logic                 latch_ce
);
	logic [7:0]      prg0;
	logic [7:0]      prg1;
	logic [7:0][8:0] chr;
	logic            swp_mode;
	logic [1:0]      mir_mode;
	logic            vrc2_latch;
	logic            sst_wr;
	logic            cpu_wr;
	logic            chr_hit;
	logic [3:0]      chr_page;
	logic [2:0]      chr_slot;
	logic [7:0]      sst_chr_lo;
	logic [7:0]      sst_chr_hi;

	assign sst_wr = sst.act && sst.we_reg;
	assign cpu_wr = !cpu.rw;

	// VRC2 microwire latch sits in 6000-6FFF when there is no PRG RAM.
	assign latch_ce = cpu.addr[15:12] == vrc_pkg::SRM_BASE[15:12] &&
		cfg.prg_ram_off && !sel.is_vrc4;

	assign chr_hit = sel.reg_addr[15:12] >= vrc_pkg::REG_CHR_FIRST[15:12] &&
		sel.reg_addr[15:12] <= vrc_pkg::REG_CHR_LAST[15:12];
	assign chr_page = sel.reg_addr[15:12] - vrc_pkg::REG_CHR_FIRST[15:12];
	assign chr_slot = {chr_page[1:0], sel.reg_addr[1]}; // Two slots per page.

	always_comb
	begin
		sst_chr_lo = '0;
		sst_chr_hi = '0;
		if (sst_wr && sst.addr.chr.grp == vrc_pkg::SST_CHR_LO[7:3])
			sst_chr_lo[sst.addr.chr.idx] = 1'b1;
		if (sst_wr && sst.addr.chr.grp == vrc_pkg::SST_CHR_HI[7:3])
			sst_chr_hi[sst.addr.chr.idx] = 1'b1;
	end

	always_ff @(negedge m2)
	begin
		if (sst_wr)
		begin
			for (int i = 0; i < 8; i++)
			begin
				if (sst_chr_lo[i])
					chr[i][7:0] <= sst.dato;
				if (sst_chr_hi[i])
					chr[i][8] <= sst.dato[0];
			end
			if (sst.addr.raw == vrc_pkg::SST_PRG0)
				prg0 <= sst.dato;
			if (sst.addr.raw == vrc_pkg::SST_PRG1)
				prg1 <= sst.dato;
			if (sst.addr.raw == vrc_pkg::SST_MODE)
				{swp_mode, mir_mode} <= sst.dato[2:0];
		end
		else if (rst)
		begin
			prg0     <= 8'd0;
			prg1     <= 8'd1;
			swp_mode <= 1'b0;
			mir_mode <= 2'd3;
		end
		else if (cpu_wr)
		begin
			if (sel.reg_addr[15:2] == vrc_pkg::REG_PRG0[15:2])
				prg0 <= cpu.data;
			if (sel.reg_addr[15:2] == vrc_pkg::REG_PRG1[15:2])
				prg1 <= cpu.data;
			if (sel.reg_addr == vrc_pkg::REG_MIR)
				mir_mode <= cpu.data[1:0];
			if (sel.reg_addr == vrc_pkg::REG_SWP)
				swp_mode <= cpu.data[1] && sel.is_vrc4; // No swap on VRC2.
			if (chr_hit && !sel.reg_addr[0])
				chr[chr_slot][3:0] <= cpu.data[3:0];
			if (chr_hit && sel.reg_addr[0])
				chr[chr_slot][8:4] <= cpu.data[4:0];
			if (latch_ce)
				vrc2_latch <= cpu.data[0];
		end
	end

	always_comb
	begin
		if (sst.addr.chr.grp == vrc_pkg::SST_CHR_LO[7:3])
			sst_di = chr[sst.addr.chr.idx][7:0];
		else if (sst.addr.chr.grp == vrc_pkg::SST_CHR_HI[7:3])
			sst_di = {7'd0, chr[sst.addr.chr.idx][8]};
		else
		begin
			case (sst.addr.raw)
				vrc_pkg::SST_PRG0: sst_di = prg0;
				vrc_pkg::SST_PRG1: sst_di = prg1;
				vrc_pkg::SST_MODE: sst_di = {5'd0, swp_mode, mir_mode};
				default: sst_di = 8'hFF;
			endcase
		end
	end

	assign banks.prg0       = prg0;
	assign banks.prg1       = prg1;
	assign banks.chr        = chr;
	assign banks.swp_mode   = swp_mode;
	// One-screen modes exist only on VRC4.
	assign banks.mir_mode   = {mir_mode[1] && sel.is_vrc4, mir_mode[0]};
	assign banks.vrc2_latch = vrc2_latch;

	// A CHR slot restore lands in the register its index names.
	assert property (@(negedge m2) sst_wr && sst.addr.chr.grp == vrc_pkg::SST_CHR_LO[7:3]
		|=> chr[$past(sst.addr.chr.idx)][7:0] == $past(sst.dato))
		else $error("save-state write missed its CHR register");

endmodule

// File: vrc_reg_decode.sv
`timescale 1ns/10ps

module vrc_reg_decode (
	input  vrc_pkg::cpu_bus_t cpu,
	input  vrc_pkg::map_cfg_t cfg,
	output vrc_pkg::reg_sel_t sel
);
	logic       vrc2;
	logic [1:0] sel_21;
	logic [1:0] sel_23;
	logic [1:0] pick;

	// VRC2 boards: mapper 22, plus sub 3 of 23 and 25.
	assign vrc2 = cfg.map_idx == vrc_pkg::MAP_22 ||
		(cfg.map_sub == 2'd3 &&
		(cfg.map_idx == vrc_pkg::MAP_23 || cfg.map_idx == vrc_pkg::MAP_25));

	always_comb
	begin
		case (cfg.map_sub)
			2'd1: sel_21 = cpu.addr[2:1];
			2'd2: sel_21 = cpu.addr[7:6];
			default: sel_21 = (cpu.addr[7:6] != 2'b00) ? cpu.addr[7:6] : cpu.addr[2:1];
		endcase
	end

	always_comb
	begin
		case (cfg.map_sub)
			2'd1, 2'd3: sel_23 = cpu.addr[1:0];
			2'd2: sel_23 = cpu.addr[3:2];
			default: sel_23 = (cpu.addr[3:2] != 2'b00) ? cpu.addr[3:2] : cpu.addr[1:0];
		endcase
	end

	always_comb
	begin
		case (cfg.map_idx)
			vrc_pkg::MAP_21: pick = sel_21;
			vrc_pkg::MAP_22: pick = {cpu.addr[0], cpu.addr[1]};
			vrc_pkg::MAP_25: pick = {sel_23[0], sel_23[1]}; // Same lines as 23, swapped.
			default: pick = sel_23;
		endcase
	end

	assign sel.reg_addr = {cpu.addr[15:12], 10'd0, pick};
	assign sel.is_vrc4  = !vrc2;

endmodule

// File: vrc_pkg.sv
package vrc_pkg;

	// CPU bus as seen at the cartridge edge.
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rw;
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic        oe; // Active low.
		logic        we; // Active low.
	} ppu_bus_t;

	typedef struct packed {
		logic [7:0] map_idx;
		logic [1:0] map_sub;
		logic       chr_ram;
		logic       prg_ram_off;
	} map_cfg_t;

	typedef struct packed {
		logic [4:0] grp;
		logic [2:0] idx;
	} sst_chr_t;

	// Save-state slot number, or CHR group plus register index.
	typedef union packed {
		logic [7:0] raw;
		sst_chr_t   chr;
	} sst_addr_u;

	typedef struct packed {
		logic       act;
		logic       we_reg;
		sst_addr_u  addr;
		logic [7:0] dato;
	} sst_bus_t;

	typedef struct packed {
		logic [20:0] addr;
		logic        ce;
		logic        oe;
		logic        we;
	} mem_ctrl_t;

	typedef struct packed {
		logic [15:0] reg_addr;
		logic        is_vrc4;
	} reg_sel_t;

	typedef struct packed {
		logic [7:0]      prg0;
		logic [7:0]      prg1;
		logic [7:0][8:0] chr;
		logic            swp_mode;
		logic [1:0]      mir_mode;
		logic            vrc2_latch;
	} bank_state_t;

	localparam logic [7:0] MAP_21 = 8'd21;
	localparam logic [7:0] MAP_22 = 8'd22;
	localparam logic [7:0] MAP_23 = 8'd23;
	localparam logic [7:0] MAP_25 = 8'd25;

	// Save-state slots.
	localparam logic [7:0] SST_CHR_LO     = 8'd0;
	localparam logic [7:0] SST_CHR_HI     = 8'd8;
	localparam logic [7:0] SST_PRG0       = 8'd16;
	localparam logic [7:0] SST_PRG1       = 8'd17;
	localparam logic [7:0] SST_MODE       = 8'd18;
	localparam logic [7:0] SST_IRQ_LATCH  = 8'd32;
	localparam logic [7:0] SST_IRQ_CTRL   = 8'd33;
	localparam logic [7:0] SST_IRQ_CNT    = 8'd34;
	localparam logic [7:0] SST_IRQ_PRE_LO = 8'd35;
	localparam logic [7:0] SST_IRQ_PRE_HI = 8'd36;
	localparam logic [7:0] SST_MAP_IDX    = 8'd127;

	// Canonical register addresses.
	localparam logic [15:0] REG_PRG0         = 16'h8000;
	localparam logic [15:0] REG_MIR          = 16'h9000;
	localparam logic [15:0] REG_SWP          = 16'h9002;
	localparam logic [15:0] REG_PRG1         = 16'hA000;
	localparam logic [15:0] REG_CHR_FIRST    = 16'hB000;
	localparam logic [15:0] REG_CHR_LAST     = 16'hE000;
	localparam logic [15:0] REG_IRQ_LATCH_LO = 16'hF000;
	localparam logic [15:0] REG_IRQ_LATCH_HI = 16'hF001;
	localparam logic [15:0] REG_IRQ_CTRL     = 16'hF002;
	localparam logic [15:0] REG_IRQ_ACK      = 16'hF003;
	localparam logic [15:0] SRM_BASE         = 16'h6000;

	localparam logic [7:0] PRG_BANK_FE = 8'hFE;
	localparam logic [7:0] PRG_BANK_FF = 8'hFF;

	localparam logic [8:0] PRESCALE_STEP  = 9'd3;
	localparam logic [8:0] PRESCALE_LIMIT = 9'd341;

endpackage
